//--- files.f
hw/uart_regs_pkg.sv
hw/uart_frame_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_core.sv
hw/uart_wb.sv
test/uart_checker.sv
test/uart_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module uart_tb -f files.f -Mdir obj_dir -o uart_sim

# Result is taken from the log, not the exit status
./obj_dir/uart_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log || ! grep -q "PASS: all tests" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- test/uart_tb.sv
/*
 * Directed testbench for the Wishbone UART.
 * Drives the bus and the rx pin on the falling clock edge, decodes tx_o with
 * a serial line model and stops at the first mismatch.
 */

`timescale 1ns/100ps

module uart_tb
    import uart_regs_pkg::*;
    import uart_frame_pkg::*;
();

    localparam int               CLK_PERIOD  = 8;
    localparam logic [DIV_W-1:0] RESET_DIV   = 4;
    localparam logic [31:0]      SEED        = 32'hb823_35e0;
    localparam int               MAX_DIV     = 6;
    localparam int               FRAME_BITS  = 12;
    localparam int               WATCHDOG_NS = 200 * FRAME_BITS * MAX_DIV * CLK_PERIOD;
    localparam int               ACK_LIMIT   = 16;
    localparam int               LINE_LIMIT  = 4 * FRAME_BITS * MAX_DIV;
    localparam int               POLL_LIMIT  = 2 * FRAME_BITS * MAX_DIV;

    logic            wb_clk;
    logic            wb_rst;
    uart_reg_addr_e  wb_adr;
    logic [31:0]     wb_dat_w;
    logic [31:0]     wb_dat_r;
    logic            wb_we;
    logic [3:0]      wb_sel;
    logic            wb_stb;
    logic            wb_ack;
    logic            rx_line;
    logic            tx_line;
    int              cur_div;
    uart_rx_status_t last_status;

    uart_wb #(.DEFAULT_DIV(RESET_DIV)) UUT (
        .wb_clk_i (wb_clk),
        .wb_rst_i (wb_rst),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_we_i  (wb_we),
        .wb_sel_i (wb_sel),
        .wb_stb_i (wb_stb),
        .wb_ack_o (wb_ack),
        .rx_i     (rx_line),
        .tx_o     (tx_line)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Error reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_status(input uart_rx_status_t got, input uart_rx_status_t exp,
                                input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Parity rule, XOR for even and its inverse for odd
    function automatic logic parity_of(input logic [7:0] b, input logic even);
        return even ? ^b : ~^b;
    endfunction

    function automatic uart_rx_status_t make_status(input logic par, input logic err_p,
                                                    input logic err_f, input logic tx_empty,
                                                    input logic rx_valid);
        uart_rx_status_t s;
        s.rx_parity   = par;
        s.err_parity  = err_p;
        s.err_framing = err_f;
        s.tx_empty    = tx_empty;
        s.rx_valid    = rx_valid;
        return s;
    endfunction

    function automatic logic [31:0] lcr_word(input logic lb, input logic even, input logic par,
                                             input logic two, input logic tx, input logic rx);
        uart_lcr_t l;
        l             = '0;
        l.loopback    = lb;
        l.even_parity = even;
        l.parity_en   = par;
        l.two_stop    = two;
        l.tx_en       = tx;
        l.rx_en       = rx;
        return {24'b0, l};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic wb_write(input uart_reg_addr_e adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        int n;
        n = 0;
        @(negedge wb_clk);
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        wb_we    = 1'b1;
        wb_stb   = 1'b1;
        while (wb_ack !== 1'b1) begin
            @(negedge wb_clk);
            n++;
            if (n > ACK_LIMIT) stop_on_error("No acknowledge on a bus write");
        end
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input uart_reg_addr_e adr, output logic [31:0] dat);
        int n;
        n = 0;
        @(negedge wb_clk);
        wb_adr = adr;
        wb_sel = 4'hF;
        wb_we  = 1'b0;
        wb_stb = 1'b1;
        while (wb_ack !== 1'b1) begin
            @(negedge wb_clk);
            n++;
            if (n > ACK_LIMIT) stop_on_error("No acknowledge on a bus read");
        end
        // Read data valid while ack is high
        dat    = wb_dat_r;
        wb_stb = 1'b0;
    endtask

    task automatic read_status(output uart_rx_status_t s);
        logic [31:0] w;
        wb_read(REG_LSR, w);
        check_word(w & ~32'h1F, 32'h0, "LSR upper bits");
        s = uart_rx_status_t'(w[4:0]);
    endtask

    task automatic wait_rx_valid();
        uart_rx_status_t s;
        int n;
        n = 0;
        read_status(s);
        while (!s.rx_valid) begin
            n++;
            if (n > POLL_LIMIT) stop_on_error("Timed out polling LSR for rx_valid");
            read_status(s);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Serial line model
    ////////////////////////////////////////////////////////////////////////////

    // One bit on rx_i, held for cur_div cycles
    task automatic send_bit(input logic b);
        @(negedge wb_clk);
        rx_line = b;
        repeat (cur_div - 1) @(negedge wb_clk);
    endtask

    task automatic send_frame(input logic [7:0] b, input logic par_en, input logic par_bit,
                              input logic stop_bit);
        int i;
        send_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            send_bit(b[i]);
        end
        if (par_en) send_bit(par_bit);
        send_bit(stop_bit);
        // Idle gap
        send_bit(1'b1);
        send_bit(1'b1);
    endtask

    // Samples tx_o every cycle of one bit, value must hold throughout
    task automatic line_bit(output logic v);
        @(negedge wb_clk);
        v = tx_line;
        repeat (cur_div - 1) begin
            @(negedge wb_clk);
            if (tx_line !== v) begin
                stop_on_error($sformatf("FAIL at %0t ns: tx_o changed inside a %0d cycle bit",
                                        $time, cur_div));
            end
        end
    endtask

    task automatic receive_frame(input logic par_en, input logic even, input logic two_stop,
                                 input logic [7:0] exp);
        int         n;
        int         i;
        logic       v;
        logic [7:0] b;
        n = 0;
        @(negedge wb_clk);
        while (tx_line !== 1'b0) begin
            n++;
            if (n > LINE_LIMIT) stop_on_error("No start bit seen on tx_o");
            @(negedge wb_clk);
        end
        // First start bit sample already taken
        repeat (cur_div - 1) begin
            @(negedge wb_clk);
            if (tx_line !== 1'b0) begin
                stop_on_error($sformatf("FAIL at %0t ns: start bit shorter than %0d cycles",
                                        $time, cur_div));
            end
        end
        for (i = 0; i < 8; i++) begin
            line_bit(v);
            b[i] = v;
        end
        check_byte(b, exp, "tx data");
        if (par_en) begin
            line_bit(v);
            check_byte({7'b0, v}, {7'b0, parity_of(exp, even)}, "tx parity bit");
        end
        line_bit(v);
        check_byte({7'b0, v}, 8'h01, "tx stop bit");
        if (two_stop) begin
            line_bit(v);
            check_byte({7'b0, v}, 8'h01, "tx second stop bit");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic read_reset_values();
        logic [31:0]     w;
        uart_rx_status_t s;
        wb_read(REG_LCR, w);
        check_word(w, 32'h0, "LCR after reset");
        wb_read(REG_DIV, w);
        check_word(w, RESET_DIV, "DIV after reset");
        read_status(s);
        check_status(s, make_status(1'b0, 1'b0, 1'b0, 1'b1, 1'b0), "LSR after reset");
    endtask

    task automatic write_div_lanes();
        logic [31:0]     exp;
        logic [31:0]     w;
        logic [31:0]     r;
        uart_rx_status_t s;
        int              lane;
        exp = RESET_DIV;
        // One lane at a time merges into the old value
        for (lane = 0; lane < 4; lane++) begin
            w = $urandom;
            wb_write(REG_DIV, w, 4'b0001 << lane);
            exp[lane*8 +: 8] = w[lane*8 +: 8];
            wb_read(REG_DIV, r);
            check_word(r, exp, "DIV after single lane write");
        end
        w = $urandom;
        wb_write(REG_DIV, w, 4'hF);
        wb_read(REG_DIV, r);
        check_word(r, w, "DIV after full word write");
        // LSR ignores writes
        wb_write(REG_LSR, $urandom, 4'hF);
        read_status(s);
        check_status(s, make_status(1'b0, 1'b0, 1'b0, 1'b1, 1'b0), "LSR after write");
        wb_read(REG_LCR, r);
        check_word(r, 32'h0, "LCR after LSR write");
        wb_read(REG_DIV, r);
        check_word(r, w, "DIV after LSR write");
    endtask

    task automatic transmit_formats();
        logic [31:0]     w;
        logic [7:0]      b;
        logic            par_en;
        logic            even;
        logic            two;
        uart_rx_status_t s;
        int              k;
        wb_write(REG_DIV, 32'd6, 4'hF);
        cur_div = 6;
        // Parity off, even, odd, two stop bits
        for (k = 0; k < 4; k++) begin
            par_en = (k == 1) || (k == 2);
            even   = (k == 1);
            two    = (k == 3);
            wb_write(REG_LCR, lcr_word(1'b0, even, par_en, two, 1'b1, 1'b0), 4'h1);
            read_status(s);
            check_status(s, make_status(1'b0, 1'b0, 1'b0, 1'b1, 1'b0), "LSR before transmit");
            w = $urandom;
            b = w[7:0];
            wb_write(REG_DATA, {24'b0, b}, 4'h1);
            receive_frame(par_en, even, two, b);
        end
    endtask

    task automatic loop_back_bytes();
        logic [31:0]     w;
        logic [7:0]      b;
        logic            even;
        uart_rx_status_t s;
        int              k;
        for (k = 0; k < 8; k++) begin
            even = k[0];
            w    = $urandom;
            b    = w[7:0];
            wb_write(REG_LCR, lcr_word(1'b1, even, 1'b1, 1'b0, 1'b1, 1'b1), 4'h1);
            wb_write(REG_DATA, {24'b0, b}, 4'h1);
            wait_rx_valid();
            wb_read(REG_DATA, w);
            check_word(w, {24'b0, b}, "loopback data");
            read_status(s);
            check_status(s, make_status(parity_of(b, even), 1'b0, 1'b0, 1'b1, 1'b0),
                         "LSR after loopback read");
        end
    endtask

    task automatic inject_line_errors();
        logic [31:0]     w;
        logic [7:0]      b;
        uart_rx_status_t s;
        wb_write(REG_LCR, lcr_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), 4'h1);
        // Wrong parity bit
        w = $urandom;
        b = w[7:0];
        send_frame(b, 1'b1, ~parity_of(b, 1'b1), 1'b1);
        wait_rx_valid();
        read_status(s);
        check_status(s, make_status(~parity_of(b, 1'b1), 1'b1, 1'b0, 1'b1, 1'b1),
                     "LSR after parity error");
        wb_read(REG_DATA, w);
        check_word(w, {24'b0, b}, "data with parity error");
        // Low stop bit
        w = $urandom;
        b = w[7:0];
        send_frame(b, 1'b1, parity_of(b, 1'b1), 1'b0);
        wait_rx_valid();
        read_status(s);
        check_status(s, make_status(parity_of(b, 1'b1), 1'b0, 1'b1, 1'b1, 1'b1),
                     "LSR after framing error");
        wb_read(REG_DATA, w);
        check_word(w, {24'b0, b}, "data with framing error");
        last_status = make_status(parity_of(b, 1'b1), 1'b0, 1'b1, 1'b1, 1'b0);
        read_status(s);
        check_status(s, last_status, "LSR after data read");
    endtask

    task automatic send_with_rx_off();
        logic [31:0]     w;
        uart_rx_status_t s;
        wb_write(REG_LCR, 32'h0, 4'h1);
        w = $urandom;
        send_frame(w[7:0], 1'b0, 1'b0, 1'b1);
        // Flags keep their last values
        read_status(s);
        check_status(s, last_status, "LSR with receiver disabled");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        wb_rst      = 1'b1;
        wb_adr      = REG_DATA;
        wb_dat_w    = 32'h0;
        wb_we       = 1'b0;
        wb_sel      = 4'h0;
        wb_stb      = 1'b0;
        rx_line     = 1'b1;
        cur_div     = RESET_DIV;
        last_status = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge wb_clk);
        @(negedge wb_clk);
        wb_rst = 1'b0;

        read_reset_values();
        write_div_lanes();
        transmit_formats();
        loop_back_bytes();
        inject_line_errors();
        send_with_rx_off();

        $display("PASS: all tests");
        $finish;
    end

    // 200 frames at the largest divisor
    initial begin
        #(WATCHDOG_NS);
        stop_on_error("Watchdog expired before the tests finished");
    end

endmodule

//--- test/uart_checker.sv
/*
 * Bus and line assertions for the UART top level.
 * Bound to uart_wb, checks acknowledge timing and the idle level of tx_o.
 */

`timescale 1ns/100ps

module uart_checker (
    input logic wb_clk_i,
    input logic wb_rst_i,
    input logic stb_i,
    input logic ack_i,
    input logic tx_i
);

    // Ack is a single cycle pulse
    ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ack_i |=> !ack_i)
        else $error("wb_ack_o high two cycles in a row");

    // New strobe answered on the next cycle
    ack_follows: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (stb_i && !ack_i) |=> ack_i)
        else $error("wb_stb_i not acknowledged within one cycle");

    // Line idles high out of reset
    tx_idle_reset: assert property (@(posedge wb_clk_i)
        wb_rst_i |=> tx_i)
        else $error("tx_o low during or just after reset");

endmodule

bind uart_wb uart_checker u_checker (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .stb_i    (wb_stb_i),
    .ack_i    (wb_ack_o),
    .tx_i     (tx_o)
);

//--- hw/uart_wb.sv
/*
 * Wishbone slave top level of the UART.
 * Holds LCR and DIV, decodes the four word registers and acknowledges each
 * strobe after one cycle. DEFAULT_DIV sets the divisor after reset.
 */

`timescale 1ns/100ps

module uart_wb
    import uart_regs_pkg::*;
    import uart_frame_pkg::*;
#(
    parameter logic [DIV_W-1:0] DEFAULT_DIV = 4
) (
    input  logic             wb_clk_i,
    input  logic             wb_rst_i,
    input  uart_reg_addr_e   wb_adr_i,
    input  logic [WB_DW-1:0] wb_dat_i,
    output logic [WB_DW-1:0] wb_dat_o,
    input  logic             wb_we_i,
    input  logic [3:0]       wb_sel_i,
    input  logic             wb_stb_i,
    output logic             wb_ack_o,
    input  logic             rx_i,
    output logic             tx_o
);

    uart_lcr_t        lcr_q;
    logic [DIV_W-1:0] div_q;
    logic             access;
    logic [3:0]       we;
    logic             dat_we;
    logic             dat_re;
    logic [7:0]       core_dat;
    uart_rx_status_t  core_status;

    // New access only in the cycle before ack
    assign access = wb_stb_i && !wb_ack_o;
    assign we     = {4{access && wb_we_i}} & wb_sel_i;

    // Data register strobes into the core
    assign dat_we = access && (wb_adr_i == REG_DATA) && wb_we_i && wb_sel_i[0];
    assign dat_re = access && (wb_adr_i == REG_DATA) && !wb_we_i;

    ////////////////////////////////////////////////////////////////////////////
    // Acknowledge and register writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            // One cycle high, then at least one low
            wb_ack_o <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            lcr_q <= LCR_RESET;
            div_q <= DEFAULT_DIV;
        end else begin
            case (wb_adr_i)
                REG_LCR: begin
                    if (we[0]) lcr_q <= uart_lcr_t'(wb_dat_i[7:0]);
                end
                REG_DIV: begin
                    // Each byte lane under its own select
                    if (we[0]) div_q[7:0]   <= wb_dat_i[7:0];
                    if (we[1]) div_q[15:8]  <= wb_dat_i[15:8];
                    if (we[2]) div_q[23:16] <= wb_dat_i[23:16];
                    if (we[3]) div_q[31:24] <= wb_dat_i[31:24];
                end
                // LSR is read only, DATA goes to the core
                default: ;
            endcase
        end
    end

    // Read mux, combinational from the address
    always_comb begin
        case (wb_adr_i)
            REG_DATA: wb_dat_o = {{(WB_DW-8){1'b0}}, core_dat};
            REG_LCR:  wb_dat_o = {{(WB_DW-8){1'b0}}, lcr_q};
            REG_LSR:  wb_dat_o = {{(WB_DW-5){1'b0}}, core_status};
            default:  wb_dat_o = div_q;
        endcase
    end

    uart_core u_core (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .divisor_i (div_q),
        .lcr_i     (lcr_q),
        .dat_we_i  (dat_we),
        .dat_re_i  (dat_re),
        .dat_i     (wb_dat_i[7:0]),
        .dat_o     (core_dat),
        .status_o  (core_status),
        .rx_i      (rx_i),
        .tx_o      (tx_o)
    );

endmodule

//--- hw/uart_core.sv
/*
 * UART core between the register block and the serial pins.
 * Holds one character per direction, selects loopback and collects the
 * receive flags into the line status struct.
 */

`timescale 1ns/100ps

module uart_core
    import uart_regs_pkg::*;
    import uart_frame_pkg::*;
(
    input  logic             wb_clk_i,
    input  logic             wb_rst_i,
    input  logic [DIV_W-1:0] divisor_i,
    input  uart_lcr_t        lcr_i,
    input  logic             dat_we_i,
    input  logic             dat_re_i,
    input  logic [7:0]       dat_i,
    output logic [7:0]       dat_o,
    output uart_rx_status_t  status_o,
    input  logic             rx_i,
    output logic             tx_o
);

    uart_frame_cfg_t frame_cfg;
    logic [7:0]      tx_buf_q;
    logic            tx_full_q;
    logic            tx_valid;
    logic            tx_ready;
    logic            rx_line;
    logic            rx_done;
    logic [7:0]      rx_byte;
    logic            rx_err_framing;
    logic            rx_err_parity;
    logic            rx_parity;
    logic [7:0]      rx_buf_q;
    logic            rx_valid_q;
    logic            err_framing_q;
    logic            err_parity_q;
    logic            parity_q;

    assign frame_cfg = '{parity_en:   lcr_i.parity_en,
                         even_parity: lcr_i.even_parity,
                         two_stop:    lcr_i.two_stop};

    // Receiver sees idle when disabled, own tx in loopback
    assign rx_line = !lcr_i.rx_en ? 1'b1 : (lcr_i.loopback ? tx_o : rx_i);

    assign tx_valid = tx_full_q;

    ////////////////////////////////////////////////////////////////////////////
    // Holding buffers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        // Character payloads
        if (dat_we_i && !tx_full_q) begin
            tx_buf_q <= dat_i;
        end
        if (rx_done) begin
            rx_buf_q <= rx_byte;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            tx_full_q     <= 1'b0;
            rx_valid_q    <= 1'b0;
            err_framing_q <= 1'b0;
            err_parity_q  <= 1'b0;
            parity_q      <= 1'b0;
        end else begin
            // Write into a full buffer is dropped
            if (dat_we_i && !tx_full_q) begin
                tx_full_q <= 1'b1;
            end else if (tx_valid && tx_ready) begin
                tx_full_q <= 1'b0;
            end
            // New character overwrites an unread one
            if (rx_done) begin
                rx_valid_q    <= 1'b1;
                err_framing_q <= rx_err_framing;
                err_parity_q  <= rx_err_parity;
                parity_q      <= rx_parity;
            end else if (dat_re_i) begin
                rx_valid_q <= 1'b0;
            end
        end
    end

    assign dat_o    = rx_buf_q;
    assign status_o = '{rx_parity:   parity_q,
                        err_parity:  err_parity_q,
                        err_framing: err_framing_q,
                        tx_empty:    !tx_full_q,
                        rx_valid:    rx_valid_q};

    uart_tx u_tx (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .divisor_i (divisor_i),
        .cfg_i     (frame_cfg),
        .en_i      (lcr_i.tx_en),
        .data_i    (tx_buf_q),
        .valid_i   (tx_valid),
        .ready_o   (tx_ready),
        .tx_o      (tx_o)
    );

    uart_rx u_rx (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .divisor_i     (divisor_i),
        .cfg_i         (frame_cfg),
        .rx_i          (rx_line),
        .done_o        (rx_done),
        .data_o        (rx_byte),
        .err_framing_o (rx_err_framing),
        .err_parity_o  (rx_err_parity),
        .parity_o      (rx_parity)
    );

endmodule

//--- hw/uart_rx.sv
/*
 * UART deserializer.
 * Synchronizes the line, starts on a falling edge and samples each bit at
 * mid-bit. Pulses done_o at the middle of the last stop bit with the byte
 * and its parity and framing flags.
 */

`timescale 1ns/100ps

module uart_rx
    import uart_frame_pkg::*;
(
    input  logic             wb_clk_i,
    input  logic             wb_rst_i,
    input  logic [DIV_W-1:0] divisor_i,
    input  uart_frame_cfg_t  cfg_i,
    input  logic             rx_i,
    output logic             done_o,
    output logic [7:0]       data_o,
    output logic             err_framing_o,
    output logic             err_parity_o,
    output logic             parity_o
);

    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

    rx_state_e        state_q;
    logic [1:0]       sync_q;
    logic             rx_last_q;
    logic             rx_s;
    logic [DIV_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic             second_q;
    logic [7:0]       shift_q;
    logic             par_q;
    logic             stop_err_q;
    logic             fall;
    logic             sample;
    logic             par_exp;
    logic             finish;

    // Synchronized line
    assign rx_s = sync_q[1];
    assign fall = rx_last_q && !rx_s;

    // Start bit is checked half a bit in, later bits one full bit apart
    assign sample = (state_q == RX_START) ? (cnt_q == (divisor_i >> 1))
                                          : (cnt_q == divisor_i - 1);

    assign par_exp = cfg_i.even_parity ? ^shift_q : ~^shift_q;

    // Sample point of the last stop bit
    assign finish = (state_q == RX_STOP) && sample && !(cfg_i.two_stop && !second_q);

    ////////////////////////////////////////////////////////////////////////////
    // Payload capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (state_q == RX_IDLE && fall) begin
            par_q <= 1'b0;
        end
        if (sample) begin
            case (state_q)
                RX_DATA:   shift_q <= {rx_s, shift_q[7:1]};
                RX_PARITY: par_q   <= rx_s;
                RX_STOP: begin
                    // Only the first stop bit is checked
                    if (!second_q) begin
                        stop_err_q <= !rx_s;
                    end
                end
                default: ;
            endcase
        end
        if (finish) begin
            data_o        <= shift_q;
            parity_o      <= par_q;
            err_parity_o  <= cfg_i.parity_en && (par_q != par_exp);
            err_framing_o <= second_q ? stop_err_q : !rx_s;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sync_q    <= 2'b11;
            rx_last_q <= 1'b1;
            state_q   <= RX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            second_q  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            // Two-flop synchronizer and edge history
            sync_q    <= {sync_q[0], rx_i};
            rx_last_q <= rx_s;
            done_o    <= finish;

            if (state_q == RX_IDLE) begin
                if (fall) begin
                    state_q <= RX_START;
                    cnt_q   <= '0;
                end
            end else if (!sample) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
                case (state_q)
                    RX_START: begin
                        // Glitch, back to idle
                        state_q   <= rx_s ? RX_IDLE : RX_DATA;
                        bit_idx_q <= '0;
                    end
                    RX_DATA: begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q  <= cfg_i.parity_en ? RX_PARITY : RX_STOP;
                            second_q <= 1'b0;
                        end
                    end
                    RX_PARITY: state_q <= RX_STOP;
                    default: begin
                        if (finish) begin
                            state_q <= RX_IDLE;
                        end else begin
                            second_q <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- hw/uart_tx.sv
/*
 * UART serializer.
 * Accepts a byte on a valid/ready handshake while idle and enabled, then
 * shifts out start, 8 data bits LSB first, optional parity and 1 or 2 stops.
 */

`timescale 1ns/100ps

module uart_tx
    import uart_frame_pkg::*;
(
    input  logic             wb_clk_i,
    input  logic             wb_rst_i,
    input  logic [DIV_W-1:0] divisor_i,
    input  uart_frame_cfg_t  cfg_i,
    input  logic             en_i,
    input  logic [7:0]       data_i,
    input  logic             valid_i,
    output logic             ready_o,
    output logic             tx_o
);

    typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

    tx_state_e        state_q;
    logic [DIV_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic             second_q;
    logic             tx_q;
    logic [7:0]       shift_q;
    logic             par_q;
    logic             bit_end;
    logic             accept;

    // Last cycle of the current bit
    assign bit_end = (cnt_q == divisor_i - 1);
    assign ready_o = (state_q == TX_IDLE) && en_i;
    assign accept  = valid_i && ready_o;
    assign tx_o    = tx_q;

    // Payload, loaded on accept and shifted after each data bit
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            shift_q <= data_i;
            // Even parity is plain XOR, odd is its inverse
            par_q   <= cfg_i.even_parity ? ^data_i : ~^data_i;
        end else if (state_q == TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bit sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q   <= TX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            second_q  <= 1'b0;
            tx_q      <= 1'b1;
        end else if (state_q == TX_IDLE) begin
            if (accept) begin
                state_q <= TX_START;
                cnt_q   <= '0;
                tx_q    <= 1'b0;
            end
        end else if (!bit_end) begin
            cnt_q <= cnt_q + 1'b1;
        end else begin
            cnt_q <= '0;
            case (state_q)
                TX_START: begin
                    state_q   <= TX_DATA;
                    bit_idx_q <= '0;
                    tx_q      <= shift_q[0];
                end
                TX_DATA: begin
                    if (bit_idx_q == 3'd7) begin
                        // Last data bit done
                        state_q  <= cfg_i.parity_en ? TX_PARITY : TX_STOP;
                        tx_q     <= cfg_i.parity_en ? par_q : 1'b1;
                        second_q <= 1'b0;
                    end else begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        tx_q      <= shift_q[1];
                    end
                end
                TX_PARITY: begin
                    state_q <= TX_STOP;
                    tx_q    <= 1'b1;
                end
                default: begin
                    // Stop bits, line already high
                    if (cfg_i.two_stop && !second_q) begin
                        second_q <= 1'b1;
                    end else begin
                        state_q <= TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/uart_frame_pkg.sv
/*
 * Serial frame definitions shared by the core, transmitter and receiver.
 * Frame format settings, receive status layout and divisor width.
 */

package uart_frame_pkg;

    // Divisor register width
    localparam int DIV_W = 32;

    // Frame format, derived from LCR by the core
    typedef struct packed {
        logic parity_en;
        logic even_parity;
        logic two_stop;
    } uart_frame_cfg_t;

    // Status bits, MSB first
    // Same layout as LSR bits 4 to 0
    typedef struct packed {
        logic rx_parity;     // Parity bit as received
        logic err_parity;
        logic err_framing;   // First stop bit was low
        logic tx_empty;      // Transmit holding buffer free
        logic rx_valid;      // Unread character in receive buffer
    } uart_rx_status_t;

endpackage

//--- hw/uart_regs_pkg.sv
/*
 * Bus-side definitions for the UART register block.
 * Register indices, the line control field layout and Wishbone data width.
 * Imported by the Wishbone slave and by the core for the LCR fields.
 */

package uart_regs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    // Word index on wb_adr_i
    typedef enum logic [1:0] {
        REG_DATA = 2'd0,    // THR on write, RBR on read
        REG_LCR  = 2'd1,    // Line control
        REG_LSR  = 2'd2,    // Line status, read only
        REG_DIV  = 2'd3     // Baud divisor in clock cycles per bit
    } uart_reg_addr_e;

    ////////////////////////////////////////////////////////////////////////////
    // Line control register
    ////////////////////////////////////////////////////////////////////////////

    // Lives in byte lane 0, MSB first
    typedef struct packed {
        logic       loopback;       // tx fed back into rx
        logic [1:0] reserved;
        logic       even_parity;    // Clear selects odd parity
        logic       parity_en;
        logic       two_stop;       // Two stop bits instead of one
        logic       tx_en;
        logic       rx_en;
    } uart_lcr_t;

    // Bus data width
    localparam int WB_DW = 32;

    // LCR after reset, everything off
    localparam uart_lcr_t LCR_RESET = '0;

endpackage
